// ==== ctrl.f ====
common/core_pkg.sv
common/trap_pkg.sv
source/irq_prio.sv
ctrl/exc_detect.sv
ctrl/ctrl_fsm.sv
ctrl/ctrl_top.sv
sim/ctrl_asserts.sv
sim/ctrl_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = ctrl_tb
FILELIST  = ctrl.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "FAIL: no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/ctrl_tb.sv ====
//////////////////////////////////////////////////
// controller testbench
// directed tests for boot, traps, irqs, sleep and branches
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_tb
  import core_pkg::*;
  import trap_pkg::*;
();

  // all tests together take about 150 cycles
  localparam int TIMEOUT_CYCLES = 2000;

  // single decoder flags
  localparam dec_flags_t ILLEGAL_FL = '{illegal: 1'b1, default: 1'b0};
  localparam dec_flags_t ECALL_FL   = '{ecall: 1'b1, default: 1'b0};
  localparam dec_flags_t MRET_FL    = '{mret: 1'b1, default: 1'b0};
  localparam dec_flags_t WFI_FL     = '{wfi: 1'b1, default: 1'b0};
  localparam dec_flags_t EBRK_FL    = '{ebrk: 1'b1, default: 1'b0};
  // expected CSR strobe sets
  localparam csr_ctrl_t CSR_EXC  = '{save_cause: 1'b1, default: 1'b0};
  localparam csr_ctrl_t CSR_IRQ  = '{save_if: 1'b1, save_cause: 1'b1, default: 1'b0};
  localparam csr_ctrl_t CSR_MRET = '{restore_mret: 1'b1, default: 1'b0};

  logic        clk_i, rst_ni, fetch_enable_i;
  dec_flags_t  dec_i;
  logic        instr_valid_i, instr_fetch_err_i;
  xlen_t       instr_i, pc_id_i;
  logic        branch_set_i, jump_set_i, stall_id_i;
  logic        csr_mstatus_mie_i, csr_mstatus_tw_i, irq_pending_i, irq_nm_i;
  irqs_t       irqs_i;
  priv_lvl_e   priv_mode_i;
  logic        ctrl_busy_o, instr_valid_clear_o, id_in_ready_o, controller_run_o;
  logic        instr_req_o, pc_set_o, nmi_mode_o, flush_id_o, perf_jump_o, perf_tbranch_o;
  pc_sel_e     pc_mux_o;
  exc_pc_sel_e exc_pc_mux_o;
  exc_cause_t  exc_cause_o;
  csr_ctrl_t   csr_ctrl_o;
  xlen_t       csr_mtval_o;
  int          seed;
  int          fail_cnt;
  int          cycle_cnt;

  ctrl_top dut_i (.*);

  initial begin : clk_gen
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // timing helpers and compare tasks
  //////////////////////////////////////////////////

  // inputs change 1 ns after the rising edge
  task automatic wait_drive_point();
    @(posedge clk_i);
    #1;
  endtask

  // outputs are stable at the falling edge
  task automatic wait_sample_point();
    @(negedge clk_i);
  endtask

  task automatic wait_for_decode();
    wait_sample_point();
    while (controller_run_o !== 1'b1) begin
      wait_sample_point();
    end
  endtask

  task automatic stop_on_error(input string msg);
    fail_cnt++;
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic compare_cause(input string name, input exc_cause_t got, input exc_cause_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic compare_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic compare_pc_sel(input string name, input pc_sel_e got, input pc_sel_e exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic compare_csr(input string name, input csr_ctrl_t got, input csr_ctrl_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_redirect(input pc_sel_e sel, input csr_ctrl_t csr);
    compare_bit("pc_set_o", pc_set_o, 1'b1);
    compare_pc_sel("pc_mux_o", pc_mux_o, sel);
    compare_csr("csr_ctrl_o", csr_ctrl_o, csr);
  endtask

  // back to idle decode inputs, mie and fetch enable untouched
  task automatic clear_inputs();
    dec_i             = '0;
    instr_valid_i     = 1'b0;
    instr_fetch_err_i = 1'b0;
    branch_set_i      = 1'b0;
    jump_set_i        = 1'b0;
    stall_id_i        = 1'b0;
    irq_pending_i     = 1'b0;
    irq_nm_i          = 1'b0;
    irqs_i            = '0;
    priv_mode_i       = PRIV_LVL_M;
    csr_mstatus_tw_i  = 1'b0;
  endtask

  // nmi first, then highest fast id, then external, software, timer
  function automatic exc_cause_t expected_cause(input irqs_t v, input logic nm);
    exc_cause_t c;
    logic       found;
    c     = '0;
    found = 1'b0;
    for (int i = FAST_IRQS - 1; i >= 0; i--) begin
      if (!found && v.irq_fast[i]) begin
        c     = EXC_CAUSE_IRQ_FAST_0 + exc_cause_t'(i);
        found = 1'b1;
      end
    end
    if (nm) c = EXC_CAUSE_IRQ_NM;
    else if (!found && v.irq_external) c = EXC_CAUSE_IRQ_EXTERNAL_M;
    else if (!found && v.irq_software) c = EXC_CAUSE_IRQ_SOFTWARE_M;
    else if (!found && v.irq_timer) c = EXC_CAUSE_IRQ_TIMER_M;
    return c;
  endfunction

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_boot();
    wait_sample_point();
    check_redirect(PC_BOOT, '0);
    compare_bit("instr_req_o", instr_req_o, 1'b0);
    compare_bit("nmi_mode_o", nmi_mode_o, 1'b0);
    compare_bit("perf_jump_o", perf_jump_o, 1'b0);
    compare_bit("perf_tbranch_o", perf_tbranch_o, 1'b0);
    wait_drive_point();
    fetch_enable_i = 1'b1;
    wait_drive_point();
    wait_sample_point();
    // boot set cycle
    check_redirect(PC_BOOT, '0);
    compare_bit("instr_req_o", instr_req_o, 1'b1);
    wait_for_decode();
  endtask

  // instr in decode in N, trap entry in N+1, back in decode at N+2
  task automatic run_exception(input dec_flags_t flags, input logic fetch_err,
                               input logic branch, input priv_lvl_e priv,
                               input exc_cause_t cause, input xlen_t mtval);
    wait_drive_point();
    dec_i             = flags;
    instr_valid_i     = 1'b1;
    instr_fetch_err_i = fetch_err;
    branch_set_i      = branch;
    priv_mode_i       = priv;
    wait_sample_point();
    compare_bit("pc_set_o", pc_set_o, 1'b0);
    wait_drive_point();
    branch_set_i = 1'b0;
    wait_sample_point();
    check_redirect(PC_EXC, CSR_EXC);
    compare_bit("exc_pc_mux_o", exc_pc_mux_o, EXC_PC_EXC);
    compare_cause("exc_cause_o", exc_cause_o, cause);
    compare_word("csr_mtval_o", csr_mtval_o, mtval);
    // the trapping instr is dropped from ID
    compare_bit("flush_id_o", flush_id_o, 1'b1);
    compare_bit("instr_valid_clear_o", instr_valid_clear_o, 1'b1);
    wait_drive_point();
    clear_inputs();
    wait_sample_point();
    compare_bit("controller_run_o", controller_run_o, 1'b1);
  endtask

  task automatic test_exceptions();
    instr_i = 32'h1234_5073;
    pc_id_i = 32'h0000_8a4c;
    run_exception(ILLEGAL_FL, 1'b0, 1'b0, PRIV_LVL_M, EXC_CAUSE_ILLEGAL_INSN, instr_i);
    run_exception('0, 1'b1, 1'b0, PRIV_LVL_M, EXC_CAUSE_INSTR_ACCESS_FAULT, pc_id_i);
    // mret outside M-mode is illegal
    run_exception(MRET_FL, 1'b0, 1'b0, PRIV_LVL_U, EXC_CAUSE_ILLEGAL_INSN, instr_i);
    // fetch error cancels the branch
    run_exception('0, 1'b1, 1'b1, PRIV_LVL_M, EXC_CAUSE_INSTR_ACCESS_FAULT, pc_id_i);
  endtask

  task automatic test_ecall_ebreak();
    run_exception(ECALL_FL, 1'b0, 1'b0, PRIV_LVL_M, EXC_CAUSE_ECALL_MMODE, '0);
    run_exception(ECALL_FL, 1'b0, 1'b0, PRIV_LVL_U, EXC_CAUSE_ECALL_UMODE, '0);
    run_exception(EBRK_FL, 1'b0, 1'b0, PRIV_LVL_M, EXC_CAUSE_BREAKPOINT, '0);
  endtask

  task automatic take_irq(input irqs_t v, input logic nm, input exc_cause_t cause);
    wait_drive_point();
    irqs_i        = v;
    irq_pending_i = |v;
    irq_nm_i      = nm;
    wait_drive_point();
    wait_sample_point();
    check_redirect(PC_EXC, CSR_IRQ);
    compare_bit("exc_pc_mux_o", exc_pc_mux_o, EXC_PC_IRQ);
    compare_cause("exc_cause_o", exc_cause_o, cause);
    wait_drive_point();
    clear_inputs();
    wait_sample_point();
    compare_bit("controller_run_o", controller_run_o, 1'b1);
  endtask

  task automatic test_interrupts();
    irqs_t       v;
    logic [31:0] rnd;
    repeat (8) begin
      rnd = $random(seed);
      v   = irqs_t'(rnd[17:0]);
      // give the slow lines a chance to win
      if (rnd[31]) v.irq_fast = '0;
      if (v == '0) v.irq_timer = 1'b1;
      take_irq(v, 1'b0, expected_cause(v, 1'b0));
    end
    take_irq('0, 1'b1, EXC_CAUSE_IRQ_NM);
    compare_bit("nmi_mode_o", nmi_mode_o, 1'b1);
    // second nmi must not nest
    wait_drive_point();
    irq_nm_i = 1'b1;
    repeat (3) begin
      wait_sample_point();
      compare_bit("pc_set_o", pc_set_o, 1'b0);
      compare_bit("controller_run_o", controller_run_o, 1'b1);
      wait_drive_point();
    end
    clear_inputs();
    // mret leaves nmi mode
    wait_drive_point();
    dec_i         = MRET_FL;
    instr_valid_i = 1'b1;
    wait_drive_point();
    wait_sample_point();
    check_redirect(PC_ERET, CSR_MRET);
    wait_drive_point();
    clear_inputs();
    wait_sample_point();
    compare_bit("nmi_mode_o", nmi_mode_o, 1'b0);
  endtask

  task automatic test_wfi();
    wait_drive_point();
    csr_mstatus_mie_i = 1'b0;
    dec_i             = WFI_FL;
    instr_valid_i     = 1'b1;
    wait_drive_point();
    wait_drive_point();
    clear_inputs();
    // wait sleep, then sleep with no wake source
    repeat (5) begin
      wait_sample_point();
      compare_bit("ctrl_busy_o", ctrl_busy_o, 1'b0);
      compare_bit("pc_set_o", pc_set_o, 1'b0);
      compare_bit("flush_id_o", flush_id_o, 1'b1);
      wait_drive_point();
    end
    irq_pending_i = 1'b1;
    wait_sample_point();
    compare_bit("ctrl_busy_o", ctrl_busy_o, 1'b1);
    wait_drive_point();
    irq_pending_i     = 1'b0;
    csr_mstatus_mie_i = 1'b1;
    wait_for_decode();
  endtask

  task automatic test_branches();
    wait_drive_point();
    branch_set_i  = 1'b1;
    instr_valid_i = 1'b1;
    wait_sample_point();
    check_redirect(PC_JUMP, '0);
    compare_bit("perf_tbranch_o", perf_tbranch_o, 1'b1);
    compare_bit("perf_jump_o", perf_jump_o, 1'b0);
    wait_drive_point();
    branch_set_i = 1'b0;
    jump_set_i   = 1'b1;
    wait_sample_point();
    check_redirect(PC_JUMP, '0);
    compare_bit("perf_jump_o", perf_jump_o, 1'b1);
    compare_bit("perf_tbranch_o", perf_tbranch_o, 1'b0);
    wait_drive_point();
    clear_inputs();
    // pending timer irq held off by the stall
    stall_id_i       = 1'b1;
    irq_pending_i    = 1'b1;
    irqs_i.irq_timer = 1'b1;
    repeat (3) begin
      wait_sample_point();
      compare_bit("id_in_ready_o", id_in_ready_o, 1'b0);
      // stalled instr stays valid in ID
      compare_bit("instr_valid_clear_o", instr_valid_clear_o, 1'b0);
      compare_bit("flush_id_o", flush_id_o, 1'b0);
      compare_bit("pc_set_o", pc_set_o, 1'b0);
      compare_bit("controller_run_o", controller_run_o, 1'b1);
      wait_drive_point();
    end
    clear_inputs();
    take_irq(irqs_t'(18'h1_0000), 1'b0, EXC_CAUSE_IRQ_TIMER_M);
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin : main
    seed              = 32'h2a40_01fc;
    fail_cnt          = 0;
    rst_ni            = 1'b0;
    fetch_enable_i    = 1'b0;
    csr_mstatus_mie_i = 1'b1;
    instr_i           = '0;
    pc_id_i           = '0;
    clear_inputs();
    repeat (4) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    test_boot();
    test_exceptions();
    test_ecall_ebreak();
    test_interrupts();
    test_wfi();
    test_branches();
    if (fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("test failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

// ==== sim/ctrl_asserts.sv ====
//////////////////////////////////////////////////
// controller assertions
// state legality and request rules of the FSM
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_asserts
  import core_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input ctrl_fsm_e state_q,
  input logic      special_req_i,
  input logic      special_req_branch_i,
  input logic      pc_set_o
);

  // only the eight encoded states
  state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN})
    else $error("controller state out of range");

  // a branch cancel always comes with a flush request
  branch_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    special_req_branch_i |-> special_req_i)
    else $error("special_req_branch without special_req");

  // no fetch redirect while asleep
  sleep_no_pc_set: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == SLEEP) |-> !pc_set_o)
    else $error("pc_set_o high in SLEEP");

endmodule

bind ctrl_fsm ctrl_asserts asserts_i (
  .clk_i                (clk_i),
  .rst_ni               (rst_ni),
  .state_q              (state_q),
  .special_req_i        (special_req_i),
  .special_req_branch_i (special_req_branch_i),
  .pc_set_o             (pc_set_o)
);

`default_nettype wire

// ==== ctrl/ctrl_top.sv ====
//////////////////////////////////////////////////
// controller top
// exception detect, irq priority and main FSM
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_top
  import core_pkg::*;
  import trap_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_enable_i,
  output logic        ctrl_busy_o,
  // from IF-ID register and decoder
  input  dec_flags_t  dec_i,
  input  logic        instr_valid_i,
  input  xlen_t       instr_i,
  input  logic        instr_fetch_err_i,
  input  xlen_t       pc_id_i,
  output logic        instr_valid_clear_o,
  output logic        id_in_ready_o,
  output logic        controller_run_o,
  // to prefetcher
  output logic        instr_req_o,
  output logic        pc_set_o,
  output pc_sel_e     pc_mux_o,
  output exc_pc_sel_e exc_pc_mux_o,
  output exc_cause_t  exc_cause_o,
  input  logic        branch_set_i,
  input  logic        jump_set_i,
  // interrupts
  input  logic        csr_mstatus_mie_i,
  input  logic        irq_pending_i,
  input  irqs_t       irqs_i,
  input  logic        irq_nm_i,
  output logic        nmi_mode_o,
  // CSRs
  output csr_ctrl_t   csr_ctrl_o,
  output xlen_t       csr_mtval_o,
  input  priv_lvl_e   priv_mode_i,
  input  logic        csr_mstatus_tw_i,
  // stall, flush and perf
  input  logic        stall_id_i,
  output logic        flush_id_o,
  output logic        perf_jump_o,
  output logic        perf_tbranch_o
);

  dec_flags_t ins_q;
  exc_cause_t irq_cause;
  logic       fetch_err;
  logic       special_req;
  logic       special_req_branch;
  logic       exc_req_q;
  logic       illegal_q;
  logic       in_flush;

  exc_detect exc_detect_i (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .dec_i                (dec_i),
    .instr_valid_i        (instr_valid_i),
    .instr_fetch_err_i    (instr_fetch_err_i),
    .priv_mode_i          (priv_mode_i),
    .csr_mstatus_tw_i     (csr_mstatus_tw_i),
    .in_flush_i           (in_flush),
    .ins_q_o              (ins_q),
    .fetch_err_o          (fetch_err),
    .special_req_o        (special_req),
    .special_req_branch_o (special_req_branch),
    .exc_req_q_o          (exc_req_q),
    .illegal_q_o          (illegal_q)
  );

  irq_prio irq_prio_i (
    .irqs_i      (irqs_i),
    .irq_nm_i    (irq_nm_i),
    .irq_cause_o (irq_cause)
  );

  ctrl_fsm ctrl_fsm_i (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .fetch_enable_i       (fetch_enable_i),
    .instr_valid_i        (instr_valid_i),
    .instr_i              (instr_i),
    .pc_id_i              (pc_id_i),
    .ins_i                (ins_q),
    .fetch_err_i          (fetch_err),
    .special_req_i        (special_req),
    .special_req_branch_i (special_req_branch),
    .exc_req_q_i          (exc_req_q),
    .illegal_q_i          (illegal_q),
    .in_flush_o           (in_flush),
    .irq_cause_i          (irq_cause),
    .irq_nm_i             (irq_nm_i),
    .irq_pending_i        (irq_pending_i),
    .csr_mstatus_mie_i    (csr_mstatus_mie_i),
    .priv_mode_i          (priv_mode_i),
    .branch_set_i         (branch_set_i),
    .jump_set_i           (jump_set_i),
    .stall_id_i           (stall_id_i),
    .ctrl_busy_o          (ctrl_busy_o),
    .instr_req_o          (instr_req_o),
    .pc_set_o             (pc_set_o),
    .pc_mux_o             (pc_mux_o),
    .exc_pc_mux_o         (exc_pc_mux_o),
    .exc_cause_o          (exc_cause_o),
    .csr_ctrl_o           (csr_ctrl_o),
    .csr_mtval_o          (csr_mtval_o),
    .nmi_mode_o           (nmi_mode_o),
    .id_in_ready_o        (id_in_ready_o),
    .instr_valid_clear_o  (instr_valid_clear_o),
    .flush_id_o           (flush_id_o),
    .controller_run_o     (controller_run_o),
    .perf_jump_o          (perf_jump_o),
    .perf_tbranch_o       (perf_tbranch_o)
  );

endmodule

`default_nettype wire

// ==== ctrl/ctrl_fsm.sv ====
//////////////////////////////////////////////////
// controller FSM
// boot, decode, flush, sleep and trap entry with
// PC redirect, CSR strobes and ID stage stall control
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_fsm
  import core_pkg::*;
  import trap_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_enable_i,
  input  logic        instr_valid_i,
  input  xlen_t       instr_i,
  input  xlen_t       pc_id_i,
  // from exception detect
  input  dec_flags_t  ins_i,
  input  logic        fetch_err_i,
  input  logic        special_req_i,
  input  logic        special_req_branch_i,
  input  logic        exc_req_q_i,
  input  logic        illegal_q_i,
  output logic        in_flush_o,
  // interrupts
  input  exc_cause_t  irq_cause_i,
  input  logic        irq_nm_i,
  input  logic        irq_pending_i,
  input  logic        csr_mstatus_mie_i,
  input  priv_lvl_e   priv_mode_i,
  // from ID stage
  input  logic        branch_set_i,
  input  logic        jump_set_i,
  input  logic        stall_id_i,
  // to IF stage and CSRs
  output logic        ctrl_busy_o,
  output logic        instr_req_o,
  output logic        pc_set_o,
  output pc_sel_e     pc_mux_o,
  output exc_pc_sel_e exc_pc_mux_o,
  output exc_cause_t  exc_cause_o,
  output csr_ctrl_t   csr_ctrl_o,
  output xlen_t       csr_mtval_o,
  output logic        nmi_mode_o,
  output logic        id_in_ready_o,
  output logic        instr_valid_clear_o,
  output logic        flush_id_o,
  output logic        controller_run_o,
  output logic        perf_jump_o,
  output logic        perf_tbranch_o
);

  ctrl_fsm_e state_q, state_d;
  logic      nmi_mode_q, nmi_mode_d;
  logic      handle_irq;
  logic      halt_if;
  logic      flush_id;

  // no nesting while the NMI handler runs
  assign handle_irq = ~nmi_mode_q & (irq_nm_i | (irq_pending_i & csr_mstatus_mie_i));

  assign in_flush_o = (state_q == FLUSH);

  //////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////

  always_comb begin : fsm_comb
    state_d          = state_q;
    nmi_mode_d       = nmi_mode_q;
    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    // mux values only matter while pc_set is high
    pc_set_o         = 1'b0;
    pc_mux_o         = PC_BOOT;
    exc_pc_mux_o     = EXC_PC_IRQ;
    exc_cause_o      = '0;
    csr_ctrl_o       = '0;
    csr_mtval_o      = '0;
    halt_if          = 1'b0;
    flush_id         = 1'b0;
    controller_run_o = 1'b0;
    perf_jump_o      = 1'b0;
    perf_tbranch_o   = 1'b0;

    unique case (state_q)
      RESET: begin
        // hold boot address until fetch is enabled
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end
      BOOT_SET: begin
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end
      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // wake on any pending irq, even if mie is clear
        if (irq_nm_i || irq_pending_i) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end
      FIRST_FETCH: begin
        // wait for the first instr to enter ID, ID is ready once not stalled
        if (!stall_id_i) begin
          state_d = DECODE;
        end
        if (handle_irq) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end
      DECODE: begin
        controller_run_o = 1'b1;
        pc_mux_o         = PC_JUMP;
        // keep the instr in ID, FLUSH decides what to do
        if (special_req_i) begin
          state_d = FLUSH;
          halt_if = 1'b1;
        end
        // branch goes out at once unless a fetch error cancels it
        if ((branch_set_i || jump_set_i) && !special_req_branch_i) begin
          pc_set_o = 1'b1;
          // counters only see instrs valid in ID
          perf_tbranch_o = branch_set_i & instr_valid_i;
          perf_jump_o    = jump_set_i & instr_valid_i;
        end
        if (!stall_id_i && !special_req_i && handle_irq) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end
      IRQ_TAKEN: begin
        pc_mux_o     = PC_EXC;
        exc_pc_mux_o = EXC_PC_IRQ;
        if (handle_irq) begin
          pc_set_o              = 1'b1;
          csr_ctrl_o.save_if    = 1'b1;
          csr_ctrl_o.save_cause = 1'b1;
          exc_cause_o           = irq_cause_i;
          // nmi wins in irq_prio, so this is the nmi entry
          if (irq_nm_i) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = DECODE;
      end
      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;
        if (exc_req_q_i) begin
          pc_set_o              = 1'b1;
          pc_mux_o              = PC_EXC;
          exc_pc_mux_o          = EXC_PC_EXC;
          csr_ctrl_o.save_cause = 1'b1;
          // cause priority: fetch error, illegal, ecall, ebreak
          if (fetch_err_i) begin
            exc_cause_o = EXC_CAUSE_INSTR_ACCESS_FAULT;
            csr_mtval_o = pc_id_i;
          end else if (illegal_q_i) begin
            exc_cause_o = EXC_CAUSE_ILLEGAL_INSN;
            csr_mtval_o = instr_i;
          end else if (ins_i.ecall) begin
            exc_cause_o = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE :
                                                        EXC_CAUSE_ECALL_UMODE;
          end else if (ins_i.ebrk) begin
            exc_cause_o = EXC_CAUSE_BREAKPOINT;
          end
        end else if (ins_i.mret) begin
          pc_set_o                = 1'b1;
          pc_mux_o                = PC_ERET;
          csr_ctrl_o.restore_mret = 1'b1;
          // leaving the NMI handler
          nmi_mode_d              = 1'b0;
        end else if (ins_i.wfi) begin
          state_d = WAIT_SLEEP;
        end else if (ins_i.csr_flush && handle_irq) begin
          // csr write may have enabled an irq
          state_d = IRQ_TAKEN;
        end
      end
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // stall control
  //////////////////////////////////////////////////

  assign id_in_ready_o       = ~stall_id_i & ~halt_if;
  // halt keeps instr valid unless ID is flushed too
  assign instr_valid_clear_o = ~(stall_id_i | halt_if) | flush_id;
  assign flush_id_o          = flush_id;
  assign nmi_mode_o          = nmi_mode_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_regs
    if (!rst_ni) begin
      state_q    <= RESET;
      nmi_mode_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
    end
  end

endmodule

`default_nettype wire

// ==== ctrl/exc_detect.sv ====
//////////////////////////////////////////////////
// exception detect
// qualifies decoder flags, spots M-mode-only misuse and
// raises the special requests for the controller
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module exc_detect
  import core_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  input  dec_flags_t dec_i,
  input  logic       instr_valid_i,
  input  logic       instr_fetch_err_i,
  input  priv_lvl_e  priv_mode_i,
  input  logic       csr_mstatus_tw_i,
  input  logic       in_flush_i,

  output dec_flags_t ins_q_o,
  output logic       fetch_err_o,
  output logic       special_req_o,
  output logic       special_req_branch_o,
  output logic       exc_req_q_o,
  output logic       illegal_q_o
);

  logic illegal_umode;
  logic illegal_d;
  logic exc_req_d;
  logic exc_req_q;
  logic illegal_q;

  // decoder flags do not look at instr valid
  assign fetch_err_o = instr_fetch_err_i & instr_valid_i;

  // mret and trapped wfi need M-mode
  assign illegal_umode = (priv_mode_i != PRIV_LVL_M) & instr_valid_i &
                         (dec_i.mret | (csr_mstatus_tw_i & dec_i.wfi));

  always_comb begin : qualify
    ins_q_o           = dec_i & {$bits(dec_flags_t){instr_valid_i}};
    // misuse outside M-mode folds into the illegal flag
    ins_q_o.illegal   = ins_q_o.illegal | illegal_umode;
  end

  // blocked in flush so a handled exception is not raised again
  assign illegal_d = ins_q_o.illegal & ~in_flush_i;
  assign exc_req_d = (ins_q_o.ecall | ins_q_o.ebrk | illegal_d | fetch_err_o) & ~in_flush_i;

  // anything that needs the FLUSH state
  assign special_req_o = ins_q_o.mret | ins_q_o.wfi | ins_q_o.csr_flush | exc_req_d;

  // only a fetch error can cancel a taken branch
  assign special_req_branch_o = fetch_err_o & ~in_flush_i;

  // registered flags, used in FLUSH to cut the decoder path to pc_set
  always_ff @(posedge clk_i or negedge rst_ni) begin : exc_regs
    if (!rst_ni) begin
      exc_req_q <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      exc_req_q <= exc_req_d;
      illegal_q <= illegal_d;
    end
  end

  assign exc_req_q_o = exc_req_q;
  assign illegal_q_o = illegal_q;

endmodule

`default_nettype wire

// ==== source/irq_prio.sv ====
//////////////////////////////////////////////////
// interrupt priority
// picks the winning interrupt and encodes its trap cause
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module irq_prio
  import trap_pkg::*;
(
  input  irqs_t      irqs_i,
  input  logic       irq_nm_i,
  output exc_cause_t irq_cause_o
);

  fast_id_t fast_id;
  logic     fast_any;

  // fast irq encoder, highest index wins since later hits overwrite
  always_comb begin : fast_enc
    fast_id = '0;
    for (int unsigned i = 0; i < FAST_IRQS; i++) begin
      if (irqs_i.irq_fast[i]) begin
        fast_id = fast_id_t'(i);
      end
    end
  end

  assign fast_any = |irqs_i.irq_fast;

  // fixed order: nmi, fast, external, software, timer
  always_comb begin : cause_sel
    if (irq_nm_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_NM;
    end else if (fast_any) begin
      irq_cause_o = EXC_CAUSE_IRQ_FAST_0 + exc_cause_t'(fast_id);
    end else if (irqs_i.irq_external) begin
      irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irqs_i.irq_software) begin
      irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else if (irqs_i.irq_timer) begin
      irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    end else begin
      // nothing pending, value is ignored by the FSM
      irq_cause_o = '0;
    end
  end

endmodule

`default_nettype wire

// ==== common/trap_pkg.sv ====
//////////////////////////////////////////////////
// trap package
// interrupt vectors, trap cause codes and PC selectors
//////////////////////////////////////////////////

`default_nettype none

package trap_pkg;

  localparam int unsigned FAST_IRQS = 15;

  typedef logic [3:0] fast_id_t;

  // M-mode interrupt lines, already masked with mie
  typedef struct packed {
    logic                 irq_software;
    logic                 irq_timer;
    logic                 irq_external;
    logic [FAST_IRQS-1:0] irq_fast;
  } irqs_t;

  // bit 5 set marks an interrupt
  typedef logic [5:0] exc_cause_t;

  // synchronous exceptions
  localparam exc_cause_t EXC_CAUSE_INSTR_ACCESS_FAULT = 6'd1;
  localparam exc_cause_t EXC_CAUSE_ILLEGAL_INSN       = 6'd2;
  localparam exc_cause_t EXC_CAUSE_BREAKPOINT         = 6'd3;
  localparam exc_cause_t EXC_CAUSE_ECALL_UMODE        = 6'd8;
  localparam exc_cause_t EXC_CAUSE_ECALL_MMODE        = 6'd11;
  // interrupts
  localparam exc_cause_t EXC_CAUSE_IRQ_NM             = 6'd32;
  localparam exc_cause_t EXC_CAUSE_IRQ_SOFTWARE_M     = 6'd35;
  localparam exc_cause_t EXC_CAUSE_IRQ_TIMER_M        = 6'd39;
  localparam exc_cause_t EXC_CAUSE_IRQ_EXTERNAL_M     = 6'd43;
  // fast irq n maps to this base plus n
  localparam exc_cause_t EXC_CAUSE_IRQ_FAST_0         = 6'd48;

  // fetch address selector
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3
  } pc_sel_e;

  // trap vector selector
  typedef enum logic {
    EXC_PC_EXC = 1'b0,
    EXC_PC_IRQ = 1'b1
  } exc_pc_sel_e;

endpackage

`default_nettype wire

// ==== common/core_pkg.sv ====
//////////////////////////////////////////////////
// core package
// core-wide widths, privilege levels, controller states
// and the grouped decoder and CSR strobes
//////////////////////////////////////////////////

`default_nettype none

package core_pkg;

  // data and address width
  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;

  // only M and U are implemented
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // raw decoder flags, not yet qualified with instr valid
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
    logic ebrk;
    logic csr_flush;
  } dec_flags_t;

  // CSR save and restore strobes
  typedef struct packed {
    logic save_if;
    logic save_id;
    logic save_cause;
    logic restore_mret;
  } csr_ctrl_t;

  // main controller FSM
  typedef enum logic [3:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN
  } ctrl_fsm_e;

endpackage

`default_nettype wire
